// ==== rtl/sprite_pkg.sv ====
package sprite_pkg;

	// Screen and line buffer geometry
	localparam int POS_W = 9;
	localparam int LB_ADDR_W = 10;
	localparam int BORDER = 32;
	localparam int LINE_MAX = 352;

	// External memory widths
	localparam int SPRAM_ADDR_W = 7;
	localparam int SPROM_ADDR_W = 14;
	localparam int COLOUR_W = 16;

	// Attribute table layout
	localparam int ATTR_BYTES = 4;

	typedef enum logic [1:0] {
		size_32 = 2'd0,
		size_16 = 2'd1,
		size_8 = 2'd2,
		size_off = 2'd3
	} size_code_t;

	typedef enum logic [1:0] {
		lc_idle,
		lc_clear,
		lc_draw
	} line_state_t;

	typedef enum logic [3:0] {
		sc_idle,
		sc_addr0,
		sc_addr1,
		sc_byte0,
		sc_byte1,
		sc_byte2,
		sc_byte3,
		sc_request,
		sc_release
	} scan_state_t;

	typedef enum logic [3:0] {
		dr_load_start,
		dr_load_wait,
		dr_load,
		dr_idle,
		dr_setup,
		dr_fetch_wait,
		dr_get,
		dr_pal_wait,
		dr_stage,
		dr_write
	} draw_state_t;

	// Edge length in pixels for a size code, zero when not drawn
	function automatic logic [5:0] size_pixels(size_code_t code);
		case (code)
			size_32: return 6'd32;
			size_16: return 6'd16;
			size_8: return 6'd8;
			default: return 6'd0;
		endcase
	endfunction

endpackage

// ==== rtl/line_control.sv ====
`timescale 1ns/1ps

module line_control (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              hsync,
	input  logic [sprite_pkg::POS_W-1:0]      vcnt,
	input  logic [sprite_pkg::POS_W-1:0]      hcnt,
	input  logic                              scan_idle,
	input  logic                              draw_busy,
	input  logic                              pix_wr,
	input  logic [sprite_pkg::POS_W-1:0]      pix_x,
	input  logic [sprite_pkg::COLOUR_W-1:0]   pix_colour,
	input  logic [sprite_pkg::COLOUR_W-1:0]   lb_rd_data,
	output logic                              line_start,
	output logic [sprite_pkg::POS_W-1:0]      active_y,
	output logic [sprite_pkg::LB_ADDR_W-1:0]  lb_rd_addr,
	output logic                              lb_wr,
	output logic [sprite_pkg::LB_ADDR_W-1:0]  lb_wr_addr,
	output logic [sprite_pkg::COLOUR_W-1:0]   lb_wr_data,
	output logic [7:0]                        spr_r,
	output logic [7:0]                        spr_g,
	output logic [7:0]                        spr_b,
	output logic                              spr_a
);

	import sprite_pkg::*;

	line_state_t state;
	logic hsync_last;
	logic rd_slot;
	logic wr_slot;
	logic clearing;
	logic [POS_W-1:0] clear_x;

	// Slots always point at opposite halves of the buffer
	assign wr_slot = ~rd_slot;
	assign clearing = (state == lc_clear);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= lc_idle;
			hsync_last <= 1'b0;
			rd_slot <= 1'b0;
			line_start <= 1'b0;
		end
		else
		begin
			hsync_last <= hsync;
			line_start <= 1'b0;
			case (state)
				lc_idle:
				begin
					// Edges seen outside idle are dropped, so a busy line is never cut short
					if (hsync && !hsync_last)
					begin
						rd_slot <= ~rd_slot;
						active_y <= (vcnt == POS_W'(255)) ? POS_W'(BORDER)
							: vcnt + POS_W'(BORDER + 1);
						clear_x <= '0;
						state <= lc_clear;
					end
				end
				lc_clear:
				begin
					if (clear_x == POS_W'(LINE_MAX))
					begin
						line_start <= 1'b1;
						state <= lc_draw;
					end
					else
					begin
						clear_x <= clear_x + 1'b1;
					end
				end
				lc_draw:
				begin
					// scan_idle is forced low while line_start is high
					if (scan_idle && !draw_busy)
						state <= lc_idle;
				end
				default:
				begin
					state <= lc_idle;
				end
			endcase
		end
	end

	// Write port shared between the clear pass and the drawer
	assign lb_wr = clearing | pix_wr;
	assign lb_wr_addr = {wr_slot, clearing ? clear_x : pix_x};
	assign lb_wr_data = clearing ? '0 : pix_colour;

	// Display side reads the other slot
	assign lb_rd_addr = {rd_slot, hcnt + POS_W'(BORDER)};

	// 5-bit channels widened by repeating their top bits
	assign spr_r = {lb_rd_data[4:0], lb_rd_data[4:2]};
	assign spr_g = {lb_rd_data[9:5], lb_rd_data[9:7]};
	assign spr_b = {lb_rd_data[14:10], lb_rd_data[14:12]};
	assign spr_a = lb_rd_data[15];

endmodule

// ==== rtl/sprite_scanner.sv ====
`timescale 1ns/1ps

module sprite_scanner #(
	parameter int SPRITE_COUNT = 32
) (
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 line_start,
	input  logic [sprite_pkg::POS_W-1:0]         active_y,
	input  logic [7:0]                           spram_data,
	input  logic                                 job_ack,
	output logic [sprite_pkg::SPRAM_ADDR_W-1:0]  spram_addr,
	output logic                                 scan_idle,
	output logic                                 job_req,
	output logic [sprite_pkg::POS_W-1:0]         job_x,
	output logic [4:0]                           job_row,
	output sprite_pkg::size_code_t               job_size,
	output logic [5:0]                           job_image,
	output logic [1:0]                           job_palette,
	output logic                                 job_mirror
);

	import sprite_pkg::*;

	scan_state_t state;
	logic [4:0] idx;
	logic enable_q;
	logic y_high_q;

	logic [POS_W-1:0] y_full;
	logic [POS_W-1:0] row_full;
	logic [POS_W:0] y_end;
	logic [5:0] size_px;
	logic visible;
	logic last_entry;

	// Byte 1 is on spram_data while in sc_byte1
	always_comb
	begin
		y_full = {y_high_q, spram_data};
		size_px = size_pixels(job_size);
		y_end = {1'b0, y_full} + {{(POS_W - 5){1'b0}}, size_px};
		row_full = active_y - y_full;
		visible = enable_q && (job_size != size_off) && (active_y >= y_full)
			&& ({1'b0, active_y} < y_end);
	end

	assign last_entry = (idx == 5'(SPRITE_COUNT - 1));
	assign scan_idle = (state == sc_idle) && !line_start;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= sc_idle;
			job_req <= 1'b0;
			idx <= '0;
		end
		else
		begin
			case (state)
				sc_idle:
				begin
					if (line_start)
					begin
						idx <= '0;
						state <= sc_addr0;
					end
				end
				sc_addr0:
				begin
					spram_addr <= SPRAM_ADDR_W'(idx * ATTR_BYTES);
					state <= sc_addr1;
				end
				sc_addr1:
				begin
					spram_addr <= spram_addr + 1'b1;
					state <= sc_byte0;
				end
				sc_byte0:
				begin
					// Bit 6 is the collide flag, not used here
					enable_q <= spram_data[7];
					job_palette <= spram_data[5:4];
					job_size <= size_code_t'(spram_data[3:2]);
					job_mirror <= spram_data[1];
					y_high_q <= spram_data[0];
					spram_addr <= spram_addr + 1'b1;
					state <= sc_byte1;
				end
				sc_byte1:
				begin
					spram_addr <= spram_addr + 1'b1;
					if (visible)
					begin
						job_row <= row_full[4:0];
						state <= sc_byte2;
					end
					else if (last_entry)
					begin
						state <= sc_idle;
					end
					else
					begin
						idx <= idx + 1'b1;
						state <= sc_addr0;
					end
				end
				sc_byte2:
				begin
					job_image <= spram_data[7:2];
					job_x[8] <= spram_data[0];
					state <= sc_byte3;
				end
				sc_byte3:
				begin
					job_x[7:0] <= spram_data;
					job_req <= 1'b1;
					state <= sc_request;
				end
				sc_request:
				begin
					// Hold the job until the drawer has latched it
					if (job_ack)
					begin
						job_req <= 1'b0;
						state <= sc_release;
					end
				end
				sc_release:
				begin
					if (!job_ack)
					begin
						if (last_entry)
						begin
							state <= sc_idle;
						end
						else
						begin
							idx <= idx + 1'b1;
							state <= sc_addr0;
						end
					end
				end
				default:
				begin
					state <= sc_idle;
				end
			endcase
		end
	end

endmodule

// ==== rtl/sprite_drawer.sv ====
`timescale 1ns/1ps

module sprite_drawer (
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 job_req,
	input  logic [sprite_pkg::POS_W-1:0]         job_x,
	input  logic [4:0]                           job_row,
	input  sprite_pkg::size_code_t               job_size,
	input  logic [5:0]                           job_image,
	input  logic [1:0]                           job_palette,
	input  logic                                 job_mirror,
	input  logic [7:0]                           sprom_data,
	input  logic [sprite_pkg::COLOUR_W-1:0]      pal_data,
	output logic                                 job_ack,
	output logic                                 draw_busy,
	output logic [sprite_pkg::SPROM_ADDR_W-1:0]  sprom_addr,
	output logic [7:0]                           pal_addr,
	output logic                                 pix_wr,
	output logic [sprite_pkg::POS_W-1:0]         pix_x,
	output logic [sprite_pkg::COLOUR_W-1:0]      pix_colour
);

	import sprite_pkg::*;

	draw_state_t state;
	logic [2:0] load_cnt;
	logic [47:0] ofs_shift;

	// Latched job
	logic [POS_W-1:0] x_q;
	logic [4:0] row_q;
	size_code_t size_q;
	logic [5:0] image_q;
	logic [1:0] palette_q;
	logic mirror_q;

	logic [5:0] col;
	logic [5:0] size_px;
	logic last_col;
	logic [SPROM_ADDR_W-1:0] base_ofs;
	logic [SPROM_ADDR_W-1:0] image_term;
	logic [SPROM_ADDR_W-1:0] row_term;
	logic [SPROM_ADDR_W-1:0] first_addr;

	// ROM header is 32x32, 16x16, 8x8, high byte first
	always_comb
	begin
		size_px = size_pixels(size_q);
		case (size_q)
			size_32:
			begin
				base_ofs = ofs_shift[45:32];
				image_term = {image_q[3:0], 10'b0};
				row_term = {4'b0, row_q, 5'b0};
			end
			size_16:
			begin
				base_ofs = ofs_shift[29:16];
				image_term = {image_q, 8'b0};
				row_term = {6'b0, row_q[3:0], 4'b0};
			end
			default:
			begin
				base_ofs = ofs_shift[13:0];
				image_term = {2'b0, image_q, 6'b0};
				row_term = {8'b0, row_q[2:0], 3'b0};
			end
		endcase
		// Mirrored rows start one past the end and count down
		first_addr = base_ofs + image_term + row_term
			+ (mirror_q ? SPROM_ADDR_W'(size_px) : '0);
	end

	assign last_col = (col == size_px - 6'd1);
	assign draw_busy = (state != dr_idle);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= dr_load_start;
			job_ack <= 1'b0;
			pix_wr <= 1'b0;
		end
		else
		begin
			if (job_ack && !job_req)
				job_ack <= 1'b0;
			case (state)
				dr_load_start:
				begin
					sprom_addr <= '0;
					load_cnt <= '0;
					state <= dr_load_wait;
				end
				dr_load_wait:
				begin
					sprom_addr <= sprom_addr + 1'b1;
					state <= dr_load;
				end
				dr_load:
				begin
					// One header byte per cycle while the address streams ahead
					ofs_shift <= {ofs_shift[39:0], sprom_data};
					sprom_addr <= sprom_addr + 1'b1;
					load_cnt <= load_cnt + 1'b1;
					if (load_cnt == 3'd5)
						state <= dr_idle;
				end
				dr_idle:
				begin
					if (job_req && !job_ack)
					begin
						x_q <= job_x;
						row_q <= job_row;
						size_q <= job_size;
						image_q <= job_image;
						palette_q <= job_palette;
						mirror_q <= job_mirror;
						job_ack <= 1'b1;
						state <= dr_setup;
					end
				end
				dr_setup:
				begin
					sprom_addr <= first_addr;
					col <= '0;
					state <= dr_fetch_wait;
				end
				dr_fetch_wait:
				begin
					state <= dr_get;
				end
				dr_get:
				begin
					pal_addr <= {palette_q, sprom_data[4:0], 1'b0};
					sprom_addr <= mirror_q ? sprom_addr - 1'b1 : sprom_addr + 1'b1;
					state <= dr_pal_wait;
				end
				dr_pal_wait:
				begin
					state <= dr_stage;
				end
				dr_stage:
				begin
					if (pal_data[15])
					begin
						pix_wr <= 1'b1;
						pix_x <= x_q + {{(POS_W - 6){1'b0}}, col};
						pix_colour <= pal_data;
						state <= dr_write;
					end
					else if (last_col)
					begin
						state <= dr_idle;
					end
					else
					begin
						col <= col + 1'b1;
						state <= dr_get;
					end
				end
				dr_write:
				begin
					pix_wr <= 1'b0;
					if (last_col)
					begin
						state <= dr_idle;
					end
					else
					begin
						col <= col + 1'b1;
						state <= dr_get;
					end
				end
				default:
				begin
					state <= dr_idle;
				end
			endcase
		end
	end

endmodule

// ==== rtl/sprite_engine.sv ====
`timescale 1ns/1ps

module sprite_engine #(
	parameter int SPRITE_COUNT = 32
) (
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 hsync,
	input  logic [sprite_pkg::POS_W-1:0]         vcnt,
	input  logic [sprite_pkg::POS_W-1:0]         hcnt,
	output logic [sprite_pkg::SPRAM_ADDR_W-1:0]  spram_addr,
	input  logic [7:0]                           spram_data,
	output logic [sprite_pkg::SPROM_ADDR_W-1:0]  sprom_addr,
	input  logic [7:0]                           sprom_data,
	output logic [7:0]                           pal_addr,
	input  logic [sprite_pkg::COLOUR_W-1:0]      pal_data,
	output logic [sprite_pkg::LB_ADDR_W-1:0]     lb_rd_addr,
	input  logic [sprite_pkg::COLOUR_W-1:0]      lb_rd_data,
	output logic                                 lb_wr,
	output logic [sprite_pkg::LB_ADDR_W-1:0]     lb_wr_addr,
	output logic [sprite_pkg::COLOUR_W-1:0]      lb_wr_data,
	output logic [7:0]                           spr_r,
	output logic [7:0]                           spr_g,
	output logic [7:0]                           spr_b,
	output logic                                 spr_a
);

	import sprite_pkg::*;

	logic line_start;
	logic [POS_W-1:0] active_y;
	logic scan_idle;
	logic draw_busy;

	// Scanner to drawer job
	logic job_req;
	logic job_ack;
	logic [POS_W-1:0] job_x;
	logic [4:0] job_row;
	size_code_t job_size;
	logic [5:0] job_image;
	logic [1:0] job_palette;
	logic job_mirror;

	// Drawer pixel writes, slot bit added in line_control
	logic pix_wr;
	logic [POS_W-1:0] pix_x;
	logic [COLOUR_W-1:0] pix_colour;

	line_control line_control_inst (
		.clk        (clk),
		.reset      (reset),
		.hsync      (hsync),
		.vcnt       (vcnt),
		.hcnt       (hcnt),
		.scan_idle  (scan_idle),
		.draw_busy  (draw_busy),
		.pix_wr     (pix_wr),
		.pix_x      (pix_x),
		.pix_colour (pix_colour),
		.lb_rd_data (lb_rd_data),
		.line_start (line_start),
		.active_y   (active_y),
		.lb_rd_addr (lb_rd_addr),
		.lb_wr      (lb_wr),
		.lb_wr_addr (lb_wr_addr),
		.lb_wr_data (lb_wr_data),
		.spr_r      (spr_r),
		.spr_g      (spr_g),
		.spr_b      (spr_b),
		.spr_a      (spr_a)
	);

	sprite_scanner #(
		.SPRITE_COUNT (SPRITE_COUNT)
	) sprite_scanner_inst (
		.clk         (clk),
		.reset       (reset),
		.line_start  (line_start),
		.active_y    (active_y),
		.spram_data  (spram_data),
		.job_ack     (job_ack),
		.spram_addr  (spram_addr),
		.scan_idle   (scan_idle),
		.job_req     (job_req),
		.job_x       (job_x),
		.job_row     (job_row),
		.job_size    (job_size),
		.job_image   (job_image),
		.job_palette (job_palette),
		.job_mirror  (job_mirror)
	);

	sprite_drawer sprite_drawer_inst (
		.clk         (clk),
		.reset       (reset),
		.job_req     (job_req),
		.job_x       (job_x),
		.job_row     (job_row),
		.job_size    (job_size),
		.job_image   (job_image),
		.job_palette (job_palette),
		.job_mirror  (job_mirror),
		.sprom_data  (sprom_data),
		.pal_data    (pal_data),
		.job_ack     (job_ack),
		.draw_busy   (draw_busy),
		.sprom_addr  (sprom_addr),
		.pal_addr    (pal_addr),
		.pix_wr      (pix_wr),
		.pix_x       (pix_x),
		.pix_colour  (pix_colour)
	);

endmodule

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD_NS = 100
) (
	output logic clk
);

	// Free-running clock, low at time zero
	initial
	begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

endmodule

// ==== tb/sprite_engine_tb.sv ====
`timescale 1ns/1ps

module sprite_engine_tb;

	import sprite_pkg::*;

	localparam int SPRITE_COUNT = 32;
	localparam int LINE_PERIOD = 6000;
	localparam int NUM_LINES = 8;
	// One hsync period per line plus one to show the last line and one spare
	localparam int TIMEOUT_CYCLES = (NUM_LINES + 2) * LINE_PERIOD;

	logic clk;
	logic reset;
	logic hsync;
	logic [POS_W-1:0] vcnt;
	logic [POS_W-1:0] hcnt;
	logic [SPRAM_ADDR_W-1:0] spram_addr;
	logic [7:0] spram_data = '0;
	logic [SPROM_ADDR_W-1:0] sprom_addr;
	logic [7:0] sprom_data = '0;
	logic [7:0] pal_addr;
	logic [COLOUR_W-1:0] pal_data = '0;
	logic [LB_ADDR_W-1:0] lb_rd_addr;
	logic [COLOUR_W-1:0] lb_rd_data = '0;
	logic lb_wr;
	logic [LB_ADDR_W-1:0] lb_wr_addr;
	logic [COLOUR_W-1:0] lb_wr_data;
	logic [7:0] spr_r;
	logic [7:0] spr_g;
	logic [7:0] spr_b;
	logic spr_a;

	// Memory contents
	logic [7:0] spram_mem [0:127];
	logic [7:0] sprom_mem [0:16383];
	logic [COLOUR_W-1:0] pal_mem [0:255];
	logic [COLOUR_W-1:0] lb_mem [0:1023];

	logic [COLOUR_W-1:0] expected_line [1:9][0:511];
	string test_name [1:9];
	bit line_fail [1:9];

	logic [31:0] lfsr_state;
	int cycle_count = 0;
	int line_starts = 0;
	int mismatch_count = 0;
	int failed_tests;
	int other_errors;
	int check_test;
	int period_start;
	logic sweep_on;
	logic cmp_valid = 1'b0;
	logic [POS_W-1:0] cmp_h = '0;
	logic [24:0] want_px;

	tb_clock #(.PERIOD_NS(100)) tb_clock_inst (.clk(clk));

	sprite_engine #(
		.SPRITE_COUNT (SPRITE_COUNT)
	) sprite_engine_inst (
		.clk        (clk),
		.reset      (reset),
		.hsync      (hsync),
		.vcnt       (vcnt),
		.hcnt       (hcnt),
		.spram_addr (spram_addr),
		.spram_data (spram_data),
		.sprom_addr (sprom_addr),
		.sprom_data (sprom_data),
		.pal_addr   (pal_addr),
		.pal_data   (pal_data),
		.lb_rd_addr (lb_rd_addr),
		.lb_rd_data (lb_rd_data),
		.lb_wr      (lb_wr),
		.lb_wr_addr (lb_wr_addr),
		.lb_wr_data (lb_wr_data),
		.spr_r      (spr_r),
		.spr_g      (spr_g),
		.spr_b      (spr_b),
		.spr_a      (spr_a)
	);

	// All four memories return data one cycle after the address
	always @(posedge clk)
	begin
		spram_data <= spram_mem[spram_addr];
		sprom_data <= sprom_mem[sprom_addr];
		pal_data <= pal_mem[pal_addr];
		lb_rd_data <= lb_mem[lb_rd_addr];
		if (lb_wr)
			lb_mem[lb_wr_addr] <= lb_wr_data;
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (sprite_engine_inst.line_start)
			line_starts <= line_starts + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the run went past %0d cycles without finishing", TIMEOUT_CYCLES);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// Outputs lag hcnt by one cycle through the line buffer read
	always @(posedge clk)
	begin
		cmp_valid <= sweep_on;
		cmp_h <= hcnt;
	end

	always @(negedge clk)
	begin
		if (cmp_valid)
		begin
			want_px = expand_colour(expected_line[check_test][int'(cmp_h) + BORDER]);
			assert (spr_r == want_px[24:17]) else
			begin
				$display("FAILED spr_r at hcnt %h: got %h, expected %h", cmp_h, spr_r,
					want_px[24:17]);
				mismatch_count++;
			end
			assert (spr_g == want_px[16:9]) else
			begin
				$display("FAILED spr_g at hcnt %h: got %h, expected %h", cmp_h, spr_g,
					want_px[16:9]);
				mismatch_count++;
			end
			assert (spr_b == want_px[8:1]) else
			begin
				$display("FAILED spr_b at hcnt %h: got %h, expected %h", cmp_h, spr_b,
					want_px[8:1]);
				mismatch_count++;
			end
			assert (spr_a == want_px[0]) else
			begin
				$display("FAILED spr_a at hcnt %h: got %h, expected %h", cmp_h, spr_a,
					want_px[0]);
				mismatch_count++;
			end
		end
	end

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
	endtask

	function automatic int active_line(input int v);
		return (v == 255) ? BORDER : (v + BORDER + 1) % 512;
	endfunction

	// Packs r, g, b and a with each channel widened by repeating its top bits
	function automatic logic [24:0] expand_colour(input logic [15:0] c);
		logic [7:0] r8;
		logic [7:0] g8;
		logic [7:0] b8;
		r8 = {c[4:0], 3'b000} + 8'(c[4:0] >> 2);
		g8 = {c[9:5], 3'b000} + 8'(c[9:5] >> 2);
		b8 = {c[14:10], 3'b000} + 8'(c[14:10] >> 2);
		return {r8, g8, b8, c[15]};
	endfunction

	// Expected line buffer word at one position with later entries on top
	function automatic logic [15:0] ref_pixel(input int ay, input int pos);
		logic [15:0] result;
		logic [7:0] b0;
		logic [7:0] b1;
		logic [7:0] b2;
		logic [7:0] b3;
		logic [7:0] pal_index;
		logic [15:0] colour;
		int size;
		int y;
		int x;
		int row;
		int col;
		int hdr;
		int offset;
		int image;
		int addr;
		result = '0;
		for (int i = 0; i < SPRITE_COUNT; i++)
		begin
			b0 = spram_mem[i * ATTR_BYTES];
			b1 = spram_mem[i * ATTR_BYTES + 1];
			b2 = spram_mem[i * ATTR_BYTES + 2];
			b3 = spram_mem[i * ATTR_BYTES + 3];
			case (b0[3:2])
				2'd0: size = 32;
				2'd1: size = 16;
				2'd2: size = 8;
				default: size = 0;
			endcase
			y = int'({b0[0], b1});
			x = int'({b2[0], b3});
			col = (pos - x + 512) % 512;
			if (b0[7] && size != 0 && ay >= y && ay < y + size && col < size)
			begin
				row = ay - y;
				hdr = (size == 32) ? 0 : ((size == 16) ? 2 : 4);
				offset = int'({sprom_mem[hdr], sprom_mem[hdr + 1]}) % 16384;
				image = int'(b2[7:2]) % ((size == 32) ? 16 : 64);
				addr = offset + image * size * size + row * size + (b0[1] ? size - col : col);
				addr = addr % 16384;
				pal_index = {b0[5:4], sprom_mem[addr][4:0], 1'b0};
				colour = pal_mem[pal_index];
				if (colour[15])
					result = colour;
			end
		end
		return result;
	endfunction

	task automatic put_sprite(input int idx, input int en, input int pal, input int size_code,
		input int mirror, input int y, input int image, input int x);
		spram_mem[idx * ATTR_BYTES] = {1'(en), 1'b0, 2'(pal), 2'(size_code), 1'(mirror),
			1'(y >> 8)};
		spram_mem[idx * ATTR_BYTES + 1] = 8'(y);
		spram_mem[idx * ATTR_BYTES + 2] = {6'(image), 1'b0, 1'(x >> 8)};
		spram_mem[idx * ATTR_BYTES + 3] = 8'(x);
	endtask

	task automatic setup_test(input int t);
		for (int i = 0; i < 128; i++)
			spram_mem[i] = '0;
		case (t)
			1:
			begin
				test_name[t] = "all sprites disabled";
				vcnt = 9'd100;
				put_sprite(0, 0, 1, 2, 0, 130, 5, 100);
				put_sprite(5, 0, 2, 0, 0, 120, 3, 60);
				put_sprite(31, 0, 3, 1, 1, 128, 7, 200);
			end
			2:
			begin
				test_name[t] = "single 8x8 sprite";
				vcnt = 9'd60;
				put_sprite(4, 1, 1, 2, 0, 90, 5, 100);
			end
			3:
			begin
				test_name[t] = "mirrored 8x8 sprite";
				vcnt = 9'd60;
				put_sprite(4, 1, 1, 2, 1, 90, 5, 100);
			end
			4:
			begin
				// Active line is 183 and each sprite sits on or just past its edge row
				test_name[t] = "16x16 and 32x32 edge rows, size_off";
				vcnt = 9'd150;
				put_sprite(0, 1, 2, 1, 0, 168, 63, 40);
				put_sprite(1, 1, 2, 1, 0, 184, 9, 70);
				put_sprite(2, 1, 0, 0, 0, 183, 20, 100);
				put_sprite(3, 1, 0, 0, 0, 151, 2, 150);
				put_sprite(4, 1, 1, 3, 0, 183, 1, 200);
			end
			5:
			begin
				test_name[t] = "vcnt 255 wrap, last and first rows";
				vcnt = 9'd255;
				put_sprite(10, 1, 3, 0, 1, 1, 7, 40);
				put_sprite(11, 1, 1, 1, 1, 32, 33, 200);
				put_sprite(12, 1, 2, 2, 0, 24, 3, 260);
			end
			6:
			begin
				test_name[t] = "overlapping sprites";
				vcnt = 9'd20;
				put_sprite(2, 1, 1, 1, 0, 50, 4, 120);
				put_sprite(7, 1, 2, 1, 0, 45, 11, 128);
			end
			7:
			begin
				test_name[t] = "new table over a reused slot";
				vcnt = 9'd200;
				put_sprite(20, 1, 3, 2, 0, 230, 12, 250);
			end
			default:
			begin
				test_name[t] = "empty table over a reused slot";
				vcnt = 9'(t);
			end
		endcase
	endtask

	task automatic build_expected(input int t);
		int ay;
		ay = active_line(int'(vcnt));
		for (int pos = 0; pos < 512; pos++)
			expected_line[t][pos] = ref_pixel(ay, pos);
	endtask

	task automatic pulse_hsync();
		hsync = 1'b1;
		repeat (4)
		begin
			@(posedge clk);
			#1;
		end
		hsync = 1'b0;
	endtask

	// Line is done once it has started and both scanner and drawer are quiet
	task automatic wait_line_done(input int line);
		int waited;
		waited = 0;
		while (!(line_starts >= line && sprite_engine_inst.scan_idle
			&& !sprite_engine_inst.draw_busy) && waited < LINE_PERIOD - 1000)
		begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (waited >= LINE_PERIOD - 1000)
		begin
			$display("Line %0d did not finish drawing within the hsync period", line);
			line_fail[line] = 1'b1;
			other_errors++;
		end
	endtask

	task automatic run_check(input int t);
		int start_count;
		int errs;
		start_count = mismatch_count;
		check_test = t;
		for (int h = 0; h < 320; h++)
		begin
			hcnt = 9'(h);
			sweep_on = 1'b1;
			@(posedge clk);
			#1;
		end
		sweep_on = 1'b0;
		repeat (2)
		begin
			@(posedge clk);
			#1;
		end
		errs = mismatch_count - start_count + (line_fail[t] ? 1 : 0);
		if (errs == 0)
		begin
			$display("Test %0d (%s): passed", t, test_name[t]);
		end
		else
		begin
			$display("Test %0d (%s): failed with %0d errors", t, test_name[t], errs);
			failed_tests++;
		end
	endtask

	initial
	begin
		logic [31:0] value;
		reset = 1'b1;
		hsync = 1'b0;
		vcnt = '0;
		hcnt = '0;
		sweep_on = 1'b0;
		check_test = 1;
		failed_tests = 0;
		other_errors = 0;
		lfsr_state = 32'h2a92;
		for (int i = 1; i <= 9; i++)
			line_fail[i] = 1'b0;

		// ROM header puts 32x32 at 0x0040, 16x16 at 0x1000 and 8x8 at 0x2800
		sprom_mem[0] = 8'h00;
		sprom_mem[1] = 8'h40;
		sprom_mem[2] = 8'h10;
		sprom_mem[3] = 8'h00;
		sprom_mem[4] = 8'h28;
		sprom_mem[5] = 8'h00;
		for (int a = 6; a < 16384; a++)
		begin
			take_bits(8, value);
			sprom_mem[a] = 8'(value);
		end
		// Every fourth palette entry is transparent
		for (int a = 0; a < 256; a++)
		begin
			take_bits(15, value);
			pal_mem[a] = {((a / 2) % 4) != 0, 15'(value)};
		end

		setup_test(1);
		build_expected(1);
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;

		// Line p is drawn in period p and shown during period p + 1
		for (int p = 1; p <= NUM_LINES + 1; p++)
		begin
			period_start = cycle_count;
			pulse_hsync();
			if (p >= 2)
			begin
				// Sweep while the new line is being scanned and drawn
				while (line_starts < p && cycle_count - period_start < LINE_PERIOD / 2)
				begin
					@(posedge clk);
					#1;
				end
				run_check(p - 1);
			end
			wait_line_done(p);
			if (p <= NUM_LINES)
			begin
				setup_test(p + 1);
				build_expected(p + 1);
			end
			while (cycle_count - period_start < LINE_PERIOD)
			begin
				@(posedge clk);
				#1;
			end
		end

		$display("Tests run %0d, failed %0d, pixel mismatches %0d, other errors %0d",
			NUM_LINES, failed_tests, mismatch_count, other_errors);
		if (failed_tests == 0 && mismatch_count == 0 && other_errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== sprite_engine.f ====
rtl/sprite_pkg.sv
rtl/line_control.sv
rtl/sprite_scanner.sv
rtl/sprite_drawer.sv
rtl/sprite_engine.sv
tb/tb_clock.sv
tb/sprite_engine_tb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module sprite_engine_tb -f sprite_engine.f \
		--Mdir obj_dir -o sim_sprite_engine
	./obj_dir/sim_sprite_engine | tee $(LOG)
	grep -qx "NO ERRORS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
